//--- Bender.yml
package:
  name: ex_stage

sources:
  - include_dirs:
      - logic
    files:
      - logic/rv_isa_pkg.sv
      - logic/ex_bus_pkg.sv
      - logic/ex_operand_sel.sv
      - logic/ex_alu.sv
      - logic/ex_branch_unit.sv
      - logic/ex_lsu_req.sv
      - logic/ex_stage.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_ex_stage.sv

//--- compile.f
+incdir+logic
+incdir+testbench
logic/rv_isa_pkg.sv
logic/ex_bus_pkg.sv
logic/ex_operand_sel.sv
logic/ex_alu.sv
logic/ex_branch_unit.sv
logic/ex_lsu_req.sv
logic/ex_stage.sv
testbench/tb_ex_stage.sv

//--- logic/ex_alu.sv
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_alu (
    input  rv_isa_pkg::alu_op_e   op_i,
    input  logic                  word_i,
    input  ex_bus_pkg::operands_t ops_i,
    output rv_isa_pkg::xlen_t     result_o
);

    rv_isa_pkg::xlen_t a;
    rv_isa_pkg::xlen_t b;
    rv_isa_pkg::xlen_t raw;
    logic [5:0]        shamt;
    logic              a_sign;

    // word mode works on the low halves
    // srlw needs zero fill, everything else keeps the sign
    always_comb begin
        a_sign = (op_i == rv_isa_pkg::alu_srl) ? 1'b0 : ops_i.src1[31];
        if (word_i) begin
            a     = {{(`EX_XLEN-32){a_sign}}, ops_i.src1[31:0]};
            b     = {{(`EX_XLEN-32){ops_i.src2[31]}}, ops_i.src2[31:0]};
            shamt = {1'b0, ops_i.src2[4:0]};
        end else begin
            a     = ops_i.src1;
            b     = ops_i.src2;
            shamt = ops_i.src2[5:0];
        end
    end

    always_comb begin
        case (op_i)
            rv_isa_pkg::alu_add:  raw = a + b;
            rv_isa_pkg::alu_sub:  raw = a - b;
            rv_isa_pkg::alu_sll:  raw = a << shamt;
            rv_isa_pkg::alu_slt:  raw = rv_isa_pkg::xlen_t'($signed(a) < $signed(b));
            rv_isa_pkg::alu_sltu: raw = rv_isa_pkg::xlen_t'(a < b);
            rv_isa_pkg::alu_xor:  raw = a ^ b;
            rv_isa_pkg::alu_srl:  raw = a >> shamt;
            rv_isa_pkg::alu_sra:  raw = $signed(a) >>> shamt;
            rv_isa_pkg::alu_or:   raw = a | b;
            rv_isa_pkg::alu_and:  raw = a & b;
            default:              raw = '0;
        endcase
    end

    // sign-extend bit 31 in word mode
    assign result_o = word_i ? {{(`EX_XLEN-32){raw[31]}}, raw[31:0]} : raw;

endmodule

//--- logic/ex_branch_unit.sv
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_branch_unit (
    input  ex_bus_pkg::id_to_ex_t    ex_i,
    output ex_bus_pkg::br_redirect_t redirect_o
);

    rv_isa_pkg::xlen_t imm_b;
    rv_isa_pkg::xlen_t imm_j;
    rv_isa_pkg::xlen_t imm_i;
    rv_isa_pkg::xlen_t target;
    logic              eq;
    logic              lt_s;
    logic              lt_u;
    logic              cond;

    assign imm_b = {{(`EX_XLEN-13){ex_i.inst[31]}}, ex_i.inst[31], ex_i.inst[7],
                    ex_i.inst[30:25], ex_i.inst[11:8], 1'b0};
    assign imm_j = {{(`EX_XLEN-21){ex_i.inst[31]}}, ex_i.inst[31], ex_i.inst[19:12],
                    ex_i.inst[20], ex_i.inst[30:21], 1'b0};
    assign imm_i = {{(`EX_XLEN-12){ex_i.inst[31]}}, ex_i.inst[31:20]};

    assign eq   = (ex_i.rs1_data == ex_i.rs2_data);
    assign lt_s = ($signed(ex_i.rs1_data) < $signed(ex_i.rs2_data));
    assign lt_u = (ex_i.rs1_data < ex_i.rs2_data);

    always_comb begin
        case (ex_i.br_op)
            rv_isa_pkg::br_jal:  cond = 1'b1;
            rv_isa_pkg::br_jalr: cond = 1'b1;
            rv_isa_pkg::br_beq:  cond = eq;
            rv_isa_pkg::br_bne:  cond = !eq;
            rv_isa_pkg::br_blt:  cond = lt_s;
            rv_isa_pkg::br_bge:  cond = !lt_s;
            rv_isa_pkg::br_bltu: cond = lt_u;
            rv_isa_pkg::br_bgeu: cond = !lt_u;
            default:             cond = 1'b0;
        endcase
    end

    // jalr target drops bit 0
    always_comb begin
        case (ex_i.br_op)
            rv_isa_pkg::br_jal:  target = ex_i.pc + imm_j;
            rv_isa_pkg::br_jalr: target = (ex_i.rs1_data + imm_i) & ~rv_isa_pkg::xlen_t'(1);
            default:             target = ex_i.pc + imm_b;
        endcase
    end

    assign redirect_o.taken  = ex_i.valid & cond;
    assign redirect_o.target = redirect_o.taken ? target : '0;

endmodule

//--- logic/ex_bus_pkg.sv
package ex_bus_pkg;

    // decoded instruction from decode
    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::alu_op_e   alu_op;
        logic                  alu_32;
        rv_isa_pkg::src1_sel_e src1_sel;
        rv_isa_pkg::src2_sel_e src2_sel;
        rv_isa_pkg::br_op_e    br_op;
        logic                  mem_en;
        logic                  mem_we;
        rv_isa_pkg::mem_size_e mem_size;
        logic                  load_unsigned;
        logic                  rf_we;
        rv_isa_pkg::reg_addr_t rf_waddr;
        logic                  sel_rf_res;
        rv_isa_pkg::xlen_t     pc;
        rv_isa_pkg::inst_t     inst;
        rv_isa_pkg::xlen_t     rs1_data;
        rv_isa_pkg::xlen_t     rs2_data;
    } id_to_ex_t;

    // stage result towards memory
    typedef struct packed {
        logic                  valid;
        rv_isa_pkg::xlen_t     pc;
        rv_isa_pkg::xlen_t     ex_result;
        logic                  mem_en;
        logic                  mem_we;
        rv_isa_pkg::mem_size_e mem_size;
        logic                  load_unsigned;
        logic                  rf_we;
        rv_isa_pkg::reg_addr_t rf_waddr;
        // 0 takes the alu result, 1 the load data
        logic                  sel_rf_res;
    } ex_to_mem_t;

    typedef struct packed {
        logic                  rf_we;
        rv_isa_pkg::reg_addr_t rf_waddr;
        rv_isa_pkg::xlen_t     ex_result;
    } rf_bypass_t;

    typedef struct packed {
        logic              taken;
        rv_isa_pkg::xlen_t target;
    } br_redirect_t;

    typedef struct packed {
        logic                  en;
        logic                  we;
        rv_isa_pkg::xlen_t     addr;
        rv_isa_pkg::xlen_t     wdata;
        rv_isa_pkg::byte_sel_t sel;
    } dmem_req_t;

    typedef struct packed {
        rv_isa_pkg::xlen_t src1;
        rv_isa_pkg::xlen_t src2;
    } operands_t;

endpackage

//--- logic/ex_cfg.svh
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// datapath width, rv64
`define EX_XLEN 64

// raw instruction word
`define EX_INST_W 32

// register file index
`define EX_REG_AW 5

`endif

//--- logic/ex_lsu_req.sv
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_lsu_req (
    input  ex_bus_pkg::id_to_ex_t ex_i,
    input  rv_isa_pkg::xlen_t     addr_i,
    input  rv_isa_pkg::inst_t     id_inst_i,
    input  logic                  id_valid_i,
    output ex_bus_pkg::dmem_req_t dmem_req_o,
    output logic                  stall_load_o
);

    logic                  en;
    logic                  is_load;
    rv_isa_pkg::reg_addr_t id_rs1;
    rv_isa_pkg::reg_addr_t id_rs2;

    assign en = ex_i.valid & ex_i.mem_en;

    assign dmem_req_o.en   = en;
    assign dmem_req_o.we   = en & ex_i.mem_we;
    assign dmem_req_o.addr = addr_i;

    // store data truncated to size, upper bytes zero
    always_comb begin
        dmem_req_o.wdata = '0;
        dmem_req_o.sel   = '0;
        if (en) begin
            case (ex_i.mem_size)
                rv_isa_pkg::mem_byte: begin
                    dmem_req_o.wdata = {{(`EX_XLEN-8){1'b0}}, ex_i.rs2_data[7:0]};
                    dmem_req_o.sel   = 8'h01;
                end
                rv_isa_pkg::mem_half: begin
                    dmem_req_o.wdata = {{(`EX_XLEN-16){1'b0}}, ex_i.rs2_data[15:0]};
                    dmem_req_o.sel   = 8'h03;
                end
                rv_isa_pkg::mem_word: begin
                    dmem_req_o.wdata = {{(`EX_XLEN-32){1'b0}}, ex_i.rs2_data[31:0]};
                    dmem_req_o.sel   = 8'h0f;
                end
                default: begin
                    dmem_req_o.wdata = ex_i.rs2_data;
                    dmem_req_o.sel   = 8'hff;
                end
            endcase
            // loads carry no write data
            if (!ex_i.mem_we) begin
                dmem_req_o.wdata = '0;
            end
        end
    end

    // load-use check against the instruction now in decode
    assign is_load = en & ~ex_i.mem_we & (ex_i.rf_waddr != '0);
    assign id_rs1  = id_inst_i[19:15];
    assign id_rs2  = id_inst_i[24:20];

    assign stall_load_o = is_load & id_valid_i &
                          ((ex_i.rf_waddr == id_rs1) | (ex_i.rf_waddr == id_rs2));

endmodule

//--- logic/ex_operand_sel.sv
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_operand_sel (
    input  ex_bus_pkg::id_to_ex_t ex_i,
    output ex_bus_pkg::operands_t ops_o
);

    rv_isa_pkg::xlen_t imm_i;
    rv_isa_pkg::xlen_t imm_s;
    rv_isa_pkg::xlen_t imm_u;
    rv_isa_pkg::xlen_t shamt;

    // i-type, 12 bits signed
    assign imm_i = {{(`EX_XLEN-12){ex_i.inst[31]}}, ex_i.inst[31:20]};

    // s-type, split around rd field
    assign imm_s = {{(`EX_XLEN-12){ex_i.inst[31]}}, ex_i.inst[31:25], ex_i.inst[11:7]};

    // upper 20 bits, low 12 zero
    assign imm_u = {{(`EX_XLEN-32){ex_i.inst[31]}}, ex_i.inst[31:12], 12'b0};

    // 6-bit shift amount for rv64
    assign shamt = {{(`EX_XLEN-6){1'b0}}, ex_i.inst[25:20]};

    always_comb begin
        case (ex_i.src1_sel)
            rv_isa_pkg::src1_rs1:  ops_o.src1 = ex_i.rs1_data;
            rv_isa_pkg::src1_pc:   ops_o.src1 = ex_i.pc;
            rv_isa_pkg::src1_zero: ops_o.src1 = '0;
            default:               ops_o.src1 = '0;
        endcase
    end

    always_comb begin
        case (ex_i.src2_sel)
            rv_isa_pkg::src2_rs2:   ops_o.src2 = ex_i.rs2_data;
            rv_isa_pkg::src2_imm_i: ops_o.src2 = imm_i;
            rv_isa_pkg::src2_imm_u: ops_o.src2 = imm_u;
            rv_isa_pkg::src2_shamt: ops_o.src2 = shamt;
            // link value for jal and jalr
            rv_isa_pkg::src2_four:  ops_o.src2 = rv_isa_pkg::xlen_t'(4);
            rv_isa_pkg::src2_imm_s: ops_o.src2 = imm_s;
            default:                ops_o.src2 = '0;
        endcase
    end

endmodule

//--- logic/ex_stage.sv
`timescale 1ns/1ps

module ex_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall_i,
    input  logic                     flush_i,
    input  ex_bus_pkg::id_to_ex_t    id_to_ex_i,
    output ex_bus_pkg::ex_to_mem_t   ex_to_mem_o,
    output ex_bus_pkg::rf_bypass_t   bypass_o,
    output ex_bus_pkg::br_redirect_t redirect_o,
    output ex_bus_pkg::dmem_req_t    dmem_req_o,
    output logic                     stall_load_o
);

    ex_bus_pkg::id_to_ex_t ex_q;
    ex_bus_pkg::operands_t ops;
    rv_isa_pkg::xlen_t     alu_result;

    // input register, flush inserts a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_q <= '0;
        end else if (flush_i) begin
            ex_q <= '0;
        end else if (!stall_i) begin
            ex_q <= id_to_ex_i;
        end
    end

    ex_operand_sel operand_sel_i (
        .ex_i  (ex_q),
        .ops_o (ops)
    );

    ex_alu alu_i (
        .op_i     (ex_q.alu_op),
        .word_i   (ex_q.alu_32),
        .ops_i    (ops),
        .result_o (alu_result)
    );

    ex_branch_unit branch_unit_i (
        .ex_i       (ex_q),
        .redirect_o (redirect_o)
    );

    // alu sum doubles as the memory address
    ex_lsu_req lsu_req_i (
        .ex_i         (ex_q),
        .addr_i       (alu_result),
        .id_inst_i    (id_to_ex_i.inst),
        .id_valid_i   (id_to_ex_i.valid),
        .dmem_req_o   (dmem_req_o),
        .stall_load_o (stall_load_o)
    );

    assign ex_to_mem_o.valid         = ex_q.valid;
    assign ex_to_mem_o.pc            = ex_q.pc;
    assign ex_to_mem_o.ex_result     = alu_result;
    assign ex_to_mem_o.mem_en        = ex_q.mem_en;
    assign ex_to_mem_o.mem_we        = ex_q.mem_we;
    assign ex_to_mem_o.mem_size      = ex_q.mem_size;
    assign ex_to_mem_o.load_unsigned = ex_q.load_unsigned;
    assign ex_to_mem_o.rf_we         = ex_q.rf_we;
    assign ex_to_mem_o.rf_waddr      = ex_q.rf_waddr;
    assign ex_to_mem_o.sel_rf_res    = ex_q.sel_rf_res;

    // bypass back to decode
    assign bypass_o.rf_we     = ex_q.rf_we & ex_q.valid;
    assign bypass_o.rf_waddr  = ex_q.rf_waddr;
    assign bypass_o.ex_result = alu_result;

endmodule

//--- logic/rv_isa_pkg.sv
`include "ex_cfg.svh"

package rv_isa_pkg;

    typedef logic [`EX_XLEN-1:0]   xlen_t;
    typedef logic [`EX_INST_W-1:0] inst_t;
    typedef logic [`EX_REG_AW-1:0] reg_addr_t;
    // one strobe per data byte
    typedef logic [`EX_XLEN/8-1:0] byte_sel_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        src1_rs1  = 2'd0,
        src1_pc   = 2'd1,
        src1_zero = 2'd2
    } src1_sel_e;

    // four gives the link value pc+4
    typedef enum logic [2:0] {
        src2_rs2   = 3'd0,
        src2_imm_i = 3'd1,
        src2_imm_u = 3'd2,
        src2_shamt = 3'd3,
        src2_four  = 3'd4,
        src2_imm_s = 3'd5
    } src2_sel_e;

    typedef enum logic [3:0] {
        br_none = 4'd0,
        br_jal  = 4'd1,
        br_jalr = 4'd2,
        br_beq  = 4'd3,
        br_bne  = 4'd4,
        br_blt  = 4'd5,
        br_bge  = 4'd6,
        br_bltu = 4'd7,
        br_bgeu = 4'd8
    } br_op_e;

    typedef enum logic [1:0] {
        mem_byte   = 2'd0,
        mem_half   = 2'd1,
        mem_word   = 2'd2,
        mem_double = 2'd3
    } mem_size_e;

endpackage

//--- testbench/ex_ref_model.svh
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// keep the low bits of v and copy bit bits-1 upward
function automatic rv_isa_pkg::xlen_t sign_extend(input rv_isa_pkg::xlen_t v, input int bits);
    return $signed(v << (64 - bits)) >>> (64 - bits);
endfunction

// alu result for the operands decode asked for
function automatic rv_isa_pkg::xlen_t ref_result(input ex_bus_pkg::id_to_ex_t q);
    rv_isa_pkg::xlen_t a;
    rv_isa_pkg::xlen_t b;
    rv_isa_pkg::xlen_t sa;
    rv_isa_pkg::xlen_t sb;
    rv_isa_pkg::xlen_t r;
    logic [5:0]        sh;
    case (q.src1_sel)
        rv_isa_pkg::src1_rs1: a = q.rs1_data;
        rv_isa_pkg::src1_pc:  a = q.pc;
        default:              a = '0;
    endcase
    case (q.src2_sel)
        rv_isa_pkg::src2_rs2:   b = q.rs2_data;
        rv_isa_pkg::src2_imm_i: b = sign_extend(q.inst[31:20], 12);
        rv_isa_pkg::src2_imm_u: b = sign_extend({q.inst[31:12], 12'b0}, 32);
        rv_isa_pkg::src2_shamt: b = q.inst[25:20];
        rv_isa_pkg::src2_four:  b = 4;
        rv_isa_pkg::src2_imm_s: b = sign_extend({q.inst[31:25], q.inst[11:7]}, 12);
        default:                b = '0;
    endcase
    // word ops only see the low 32 bits
    sa = q.alu_32 ? sign_extend(a, 32) : a;
    sb = q.alu_32 ? sign_extend(b, 32) : b;
    sh = q.alu_32 ? {1'b0, b[4:0]} : b[5:0];
    case (q.alu_op)
        rv_isa_pkg::alu_add:  r = a + b;
        rv_isa_pkg::alu_sub:  r = a - b;
        rv_isa_pkg::alu_sll:  r = a << sh;
        rv_isa_pkg::alu_slt:  r = $signed(sa) < $signed(sb);
        // sign extension keeps the unsigned order of 32-bit values
        rv_isa_pkg::alu_sltu: r = sa < sb;
        rv_isa_pkg::alu_xor:  r = a ^ b;
        rv_isa_pkg::alu_srl:  r = (q.alu_32 ? {32'b0, a[31:0]} : a) >> sh;
        rv_isa_pkg::alu_sra:  r = $signed(sa) >>> sh;
        rv_isa_pkg::alu_or:   r = a | b;
        rv_isa_pkg::alu_and:  r = a & b;
        default:              r = '0;
    endcase
    return q.alu_32 ? sign_extend(r, 32) : r;
endfunction

function automatic ex_bus_pkg::ex_to_mem_t ref_ex_to_mem(input ex_bus_pkg::id_to_ex_t q);
    return '{valid: q.valid, pc: q.pc, ex_result: ref_result(q), mem_en: q.mem_en,
             mem_we: q.mem_we, mem_size: q.mem_size, load_unsigned: q.load_unsigned,
             rf_we: q.rf_we, rf_waddr: q.rf_waddr, sel_rf_res: q.sel_rf_res};
endfunction

function automatic ex_bus_pkg::rf_bypass_t ref_bypass(input ex_bus_pkg::id_to_ex_t q);
    return '{rf_we: q.rf_we & q.valid, rf_waddr: q.rf_waddr, ex_result: ref_result(q)};
endfunction

function automatic ex_bus_pkg::br_redirect_t ref_redirect(input ex_bus_pkg::id_to_ex_t q);
    ex_bus_pkg::br_redirect_t d;
    rv_isa_pkg::xlen_t        imm_b;
    rv_isa_pkg::xlen_t        imm_j;
    imm_b = sign_extend({q.inst[31], q.inst[7], q.inst[30:25], q.inst[11:8], 1'b0}, 13);
    imm_j = sign_extend({q.inst[31], q.inst[19:12], q.inst[20], q.inst[30:21], 1'b0}, 21);
    d.target = q.pc + imm_b;
    case (q.br_op)
        rv_isa_pkg::br_jal:  d.taken = 1'b1;
        rv_isa_pkg::br_jalr: d.taken = 1'b1;
        rv_isa_pkg::br_beq:  d.taken = q.rs1_data == q.rs2_data;
        rv_isa_pkg::br_bne:  d.taken = q.rs1_data != q.rs2_data;
        rv_isa_pkg::br_blt:  d.taken = $signed(q.rs1_data) < $signed(q.rs2_data);
        rv_isa_pkg::br_bge:  d.taken = $signed(q.rs1_data) >= $signed(q.rs2_data);
        rv_isa_pkg::br_bltu: d.taken = q.rs1_data < q.rs2_data;
        rv_isa_pkg::br_bgeu: d.taken = q.rs1_data >= q.rs2_data;
        default:             d.taken = 1'b0;
    endcase
    if (q.br_op == rv_isa_pkg::br_jal)
        d.target = q.pc + imm_j;
    // jalr lands on an even address
    if (q.br_op == rv_isa_pkg::br_jalr)
        d.target = (q.rs1_data + sign_extend(q.inst[31:20], 12)) & ~64'd1;
    d.taken = d.taken & q.valid;
    if (!d.taken)
        d.target = '0;
    return d;
endfunction

function automatic ex_bus_pkg::dmem_req_t ref_dmem(input ex_bus_pkg::id_to_ex_t q);
    ex_bus_pkg::dmem_req_t d;
    d = '0;
    d.en = q.valid & q.mem_en;
    d.we = d.en & q.mem_we;
    d.addr = ref_result(q);
    // 1, 2, 4 or 8 lanes from the bottom
    for (int i = 0; i < 8; i++) begin
        if (d.en && i < (1 << q.mem_size)) begin
            d.sel[i] = 1'b1;
            if (d.we)
                d.wdata[8*i +: 8] = q.rs2_data[8*i +: 8];
        end
    end
    return d;
endfunction

function automatic logic ref_stall_load(input ex_bus_pkg::id_to_ex_t q,
                                        input rv_isa_pkg::inst_t id_inst,
                                        input logic id_valid);
    return q.valid && q.mem_en && !q.mem_we && q.rf_waddr != 0 && id_valid &&
           (q.rf_waddr == id_inst[19:15] || q.rf_waddr == id_inst[24:20]);
endfunction

`endif

//--- testbench/tb_ex_stage.sv
`timescale 1ns/1ps

module tb_ex_stage;

    `include "ex_ref_model.svh"

    localparam int NUM_VECTORS    = 2000;
    localparam int PHASE_LEN      = NUM_VECTORS / 5;
    // vectors plus reset and drain, with some margin
    localparam int TIMEOUT_CYCLES = NUM_VECTORS + 100;

    logic                     clk;
    logic                     rst;
    logic                     stall_i;
    logic                     flush_i;
    ex_bus_pkg::id_to_ex_t    id_to_ex_i;
    ex_bus_pkg::ex_to_mem_t   ex_to_mem_o;
    ex_bus_pkg::rf_bypass_t   bypass_o;
    ex_bus_pkg::br_redirect_t redirect_o;
    ex_bus_pkg::dmem_req_t    dmem_req_o;
    logic                     stall_load_o;

    ex_bus_pkg::id_to_ex_t model_q;
    string                 model_name = "reset";
    string                 stim_name;
    string                 names [5] = '{"alu64", "alu32", "branch", "memory", "load_use"};
    integer                seed;
    int                    cycles = 0;

    ex_stage ex_stage_i (
        .clk          (clk),
        .rst          (rst),
        .stall_i      (stall_i),
        .flush_i      (flush_i),
        .id_to_ex_i   (id_to_ex_i),
        .ex_to_mem_o  (ex_to_mem_o),
        .bypass_o     (bypass_o),
        .redirect_o   (redirect_o),
        .dmem_req_o   (dmem_req_o),
        .stall_load_o (stall_load_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // model copy of the input register, plus the run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rst) begin
            model_q    <= '0;
            model_name <= "reset";
        end else if (flush_i) begin
            model_q    <= '0;
            model_name <= "flush";
        end else if (!stall_i) begin
            model_q    <= id_to_ex_i;
            model_name <= stim_name;
        end
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [159:0] expected,
                               input logic [159:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "output mismatch");
        end
    endtask

    function automatic int rand_below(input int n);
        int unsigned r;
        r = $random(seed);
        return r % n;
    endfunction

    task automatic make_stimulus(input int phase);
        ex_bus_pkg::id_to_ex_t s;
        s = '0;
        s.valid         = rand_below(8) != 0;
        s.alu_op        = rv_isa_pkg::alu_op_e'(rand_below(10));
        s.alu_32        = (phase == 1);
        s.src1_sel      = rv_isa_pkg::src1_sel_e'(rand_below(3));
        s.src2_sel      = rv_isa_pkg::src2_sel_e'(rand_below(6));
        s.pc            = {$random(seed), $random(seed)};
        s.inst          = $random(seed);
        s.rs1_data      = {$random(seed), $random(seed)};
        s.rs2_data      = (rand_below(4) == 0) ? s.rs1_data : {$random(seed), $random(seed)};
        s.rf_we         = 1'b1;
        s.rf_waddr      = (rand_below(4) == 0) ? 5'd0 : 5'(rand_below(32));
        s.load_unsigned = rand_below(2);
        case (phase)
            2: begin
                s.br_op    = rv_isa_pkg::br_op_e'(rand_below(9));
                s.rf_we    = s.br_op inside {rv_isa_pkg::br_jal, rv_isa_pkg::br_jalr};
                s.alu_op   = rv_isa_pkg::alu_add;
                s.src1_sel = rv_isa_pkg::src1_pc;
                s.src2_sel = rv_isa_pkg::src2_four;
            end
            3, 4: begin
                s.mem_en     = (phase == 3) || (rand_below(2) == 1);
                s.mem_we     = (phase == 3) ? rand_below(2) == 1 : rand_below(4) == 0;
                s.mem_size   = rv_isa_pkg::mem_size_e'(rand_below(4));
                s.alu_op     = rv_isa_pkg::alu_add;
                s.src1_sel   = rv_isa_pkg::src1_rs1;
                s.src2_sel   = s.mem_we ? rv_isa_pkg::src2_imm_s : rv_isa_pkg::src2_imm_i;
                s.rf_we      = !s.mem_we;
                s.sel_rf_res = !s.mem_we;
                // decode reads the register that the held load writes
                if (phase == 4 && rand_below(3) == 0)
                    s.inst[19:15] = model_q.rf_waddr;
                if (phase == 4 && rand_below(3) == 0)
                    s.inst[24:20] = model_q.rf_waddr;
            end
            default: ;
        endcase
        id_to_ex_i = s;
        stim_name  = names[phase];
    endtask

    initial begin
        seed       = 32'h0cf8_4018;
        rst        = 1'b1;
        stall_i    = 1'b0;
        flush_i    = 1'b0;
        id_to_ex_i = '0;
        stim_name  = "reset";
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int v = 0; v < NUM_VECTORS; v++) begin
            make_stimulus(v / PHASE_LEN);
            stall_i = rand_below(8) == 0;
            flush_i = rand_below(16) == 0;
            @(posedge clk);
            #1;
        end
        stall_i    = 1'b0;
        flush_i    = 1'b0;
        id_to_ex_i = '0;
        @(posedge clk);
        $display("Finished with no errors");
        $finish;
    end

    // compare just before the next edge
    initial begin
        forever begin
            @(posedge clk);
            #9;
            // a bubble keeps every enable low
            if (model_name == "flush" || model_name == "reset")
                check_value({model_name, " enables"}, '0,
                            {ex_to_mem_o.valid, ex_to_mem_o.rf_we, ex_to_mem_o.mem_en,
                             dmem_req_o.en, redirect_o.taken, stall_load_o});
            check_value({model_name, " ex_to_mem"}, ref_ex_to_mem(model_q), ex_to_mem_o);
            check_value({model_name, " bypass"}, ref_bypass(model_q), bypass_o);
            check_value({model_name, " redirect"}, ref_redirect(model_q), redirect_o);
            check_value({model_name, " dmem_req"}, ref_dmem(model_q), dmem_req_o);
            check_value({model_name, " stall_load"},
                        ref_stall_load(model_q, id_to_ex_i.inst, id_to_ex_i.valid),
                        stall_load_o);
        end
    end

endmodule
